/* include/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// bus widths
`define ADDR_SIZE 16
`define DATA_SIZE 32

// operand offset field of a command word
`define OFS_SIZE 8

// command codes, bits 31..28 of the command word
`define CMD_STOP 4'd0
`define CMD_ADD  4'd1
`define CMD_SUB  4'd2
`define CMD_AND  4'd3
`define CMD_OR   4'd4
`define CMD_XOR  4'd5

// cpu message, handled by the message unit
`define CMD_MSG  4'd8

`endif

/* hdl/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

  // alu view of a command word
  typedef struct packed {
    logic [3:0]           code;
    logic [`OFS_SIZE-1:0] dst;
    logic [`OFS_SIZE-1:0] src0;
    logic [`OFS_SIZE-1:0] src1;
    logic [3:0]           pad;
  } alu_cmd_t;

  // message view, target and tag sit where src1 is in the alu view
  typedef struct packed {
    logic [3:0]           code;
    logic [`OFS_SIZE-1:0] dst;
    logic [`OFS_SIZE-1:0] src0;
    logic [3:0]           target;
    logic [7:0]           tag;
  } msg_cmd_t;

  typedef union packed {
    alu_cmd_t alu;
    msg_cmd_t msg;
  } cmd_word_t;

  typedef struct packed {
    logic [`ADDR_SIZE-1:0] addr;
    logic [`DATA_SIZE-1:0] wdata;
    logic                  write;
  } mem_op_t;

  typedef struct packed {
    logic [3:0]            target;
    logic [7:0]            tag;
    logic [`DATA_SIZE-1:0] payload;
  } cpu_msg_t;

  typedef struct packed {
    logic [`ADDR_SIZE-1:0] cmd_base;
    logic [`ADDR_SIZE-1:0] data_base;
  } run_params_t;

  typedef struct packed {
    logic [`DATA_SIZE-1:0] result;
    logic                  done;
  } unit_result_t;

endpackage

/* hdl/bus_master.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module bus_master import core_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  go,
  input  mem_op_t               op,
  output logic                  done,
  output logic [`DATA_SIZE-1:0] rdata,
  output logic                  mem_req,
  input  logic                  mem_ack,
  output mem_op_t               mem_bus,
  input  logic [`DATA_SIZE-1:0] mem_rdata
);

  typedef enum logic [1:0] {
    BM_IDLE,
    BM_WAIT_HI,
    BM_WAIT_LO
  } bm_state_t;

  bm_state_t state;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= BM_IDLE;
      mem_req <= 1'b0;
      mem_bus <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        BM_IDLE: begin
          // operation stays on the bus for the whole handshake
          if (go) begin
            mem_bus <= op;
            mem_req <= 1'b1;
            state   <= BM_WAIT_HI;
          end
        end
        BM_WAIT_HI: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= BM_WAIT_LO;
          end
        end
        BM_WAIT_LO: begin
          if (!mem_ack) begin
            done  <= 1'b1;
            state <= BM_IDLE;
          end
        end
        default: state <= BM_IDLE;
      endcase
    end
  end

  // read word is valid while ack is high
  always_ff @(posedge clk) begin
    if (state == BM_WAIT_HI && mem_ack) begin
      rdata <= mem_rdata;
    end
  end

endmodule

/* hdl/cmd_sequencer.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module cmd_sequencer import core_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start_req,
  output logic                  start_ack,
  input  run_params_t           start,
  output logic                  bus_go,
  output mem_op_t               bus_op,
  input  logic                  bus_done,
  input  logic [`DATA_SIZE-1:0] bus_rdata,
  output logic                  exec,
  output cmd_word_t             cmd,
  output logic [`DATA_SIZE-1:0] src0,
  output logic [`DATA_SIZE-1:0] src1,
  input  unit_result_t          alu_res,
  input  unit_result_t          msg_res
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_READ0,
    ST_READ1,
    ST_EXEC,
    ST_WRITE,
    ST_FINISH,
    ST_RELEASE
  } seq_state_t;

  seq_state_t            state;
  run_params_t           params_q;
  logic [`ADDR_SIZE-1:0] ip;
  cmd_word_t             fetched;
  logic                  issue;
  mem_op_t               next_op;
  logic                  alu_seen;
  logic                  msg_seen;
  logic                  units_done;
  logic [`DATA_SIZE-1:0] merged;

  function automatic logic [`ADDR_SIZE-1:0] data_addr(
    input logic [`ADDR_SIZE-1:0] base,
    input logic [`OFS_SIZE-1:0]  ofs
  );
    return base + {{(`ADDR_SIZE - `OFS_SIZE){1'b0}}, ofs};
  endfunction

  assign fetched = bus_rdata;

  // the alu answers in one cycle, a message may take much longer
  assign units_done = (alu_seen | alu_res.done) & (msg_seen | msg_res.done);
  assign merged     = alu_res.result | msg_res.result;

  // next bus operation, issued on the state change
  always_comb begin
    issue   = 1'b0;
    next_op = '0;
    case (state)
      ST_IDLE: begin
        if (start_req) begin
          issue        = 1'b1;
          next_op.addr = start.cmd_base;
        end
      end
      ST_FETCH: begin
        if (bus_done && fetched.alu.code != `CMD_STOP) begin
          issue        = 1'b1;
          next_op.addr = data_addr(params_q.data_base, fetched.alu.src0);
        end
      end
      ST_READ0: begin
        if (bus_done) begin
          issue        = 1'b1;
          next_op.addr = data_addr(params_q.data_base, cmd.alu.src1);
        end
      end
      ST_EXEC: begin
        if (units_done) begin
          issue         = 1'b1;
          next_op.addr  = data_addr(params_q.data_base, cmd.alu.dst);
          next_op.wdata = merged;
          next_op.write = 1'b1;
        end
      end
      ST_WRITE: begin
        if (bus_done) begin
          issue        = 1'b1;
          next_op.addr = params_q.cmd_base + ip + 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      ip        <= '0;
      bus_go    <= 1'b0;
      exec      <= 1'b0;
      start_ack <= 1'b0;
      alu_seen  <= 1'b0;
      msg_seen  <= 1'b0;
    end else begin
      bus_go <= issue;
      exec   <= (state == ST_READ1) && bus_done;
      case (state)
        ST_IDLE: begin
          if (start_req) begin
            ip    <= '0;
            state <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (bus_done) begin
            state <= (fetched.alu.code == `CMD_STOP) ? ST_FINISH : ST_READ0;
          end
        end
        ST_READ0: if (bus_done) state <= ST_READ1;
        ST_READ1: if (bus_done) state <= ST_EXEC;
        ST_EXEC: begin
          if (units_done) begin
            alu_seen <= 1'b0;
            msg_seen <= 1'b0;
            state    <= ST_WRITE;
          end else begin
            alu_seen <= alu_seen | alu_res.done;
            msg_seen <= msg_seen | msg_res.done;
          end
        end
        ST_WRITE: begin
          if (bus_done) begin
            ip    <= ip + 1'b1;
            state <= ST_FETCH;
          end
        end
        ST_FINISH: begin
          start_ack <= 1'b1;
          state     <= ST_RELEASE;
        end
        ST_RELEASE: begin
          // agent drops req, then we drop ack
          if (!start_req) begin
            start_ack <= 1'b0;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start_req) params_q <= start;
    if (state == ST_FETCH && bus_done) cmd <= fetched;
    if (state == ST_READ0 && bus_done) src0 <= bus_rdata;
    if (state == ST_READ1 && bus_done) src1 <= bus_rdata;
    if (issue) bus_op <= next_op;
  end

endmodule

/* hdl/alu_unit.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module alu_unit import core_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  exec,
  input  cmd_word_t             cmd,
  input  logic [`DATA_SIZE-1:0] src0,
  input  logic [`DATA_SIZE-1:0] src1,
  output unit_result_t          res
);

  logic [`DATA_SIZE-1:0] alu_out;
  logic [`DATA_SIZE-1:0] result_q;
  logic                  done_q;

  // zero for anything that is not an alu code, so the results can be ORed
  always_comb begin
    case (cmd.alu.code)
      `CMD_ADD: alu_out = src0 + src1;
      // wraps below zero
      `CMD_SUB: alu_out = src0 - src1;
      `CMD_AND: alu_out = src0 & src1;
      `CMD_OR:  alu_out = src0 | src1;
      `CMD_XOR: alu_out = src0 ^ src1;
      default:  alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (exec) begin
      result_q <= alu_out;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= exec;
    end
  end

  assign res.result = result_q;
  assign res.done   = done_q;

endmodule

/* hdl/msg_unit.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module msg_unit import core_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  exec,
  input  cmd_word_t             cmd,
  input  logic [`DATA_SIZE-1:0] src0,
  output unit_result_t          res,
  output logic                  msg_req,
  input  logic                  msg_ack,
  output cpu_msg_t              msg_out,
  input  logic [`DATA_SIZE-1:0] msg_reply
);

  typedef enum logic [1:0] {
    MU_IDLE,
    MU_WAIT_HI,
    MU_WAIT_LO
  } mu_state_t;

  mu_state_t             state;
  logic [`DATA_SIZE-1:0] result_q;
  logic                  done_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= MU_IDLE;
      msg_req <= 1'b0;
      msg_out <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        MU_IDLE: begin
          if (exec && cmd.msg.code == `CMD_MSG) begin
            msg_out.target  <= cmd.msg.target;
            msg_out.tag     <= cmd.msg.tag;
            msg_out.payload <= src0;
            msg_req         <= 1'b1;
            state           <= MU_WAIT_HI;
          end else if (exec) begin
            // not ours, answer at once with zero
            done_q <= 1'b1;
          end
        end
        MU_WAIT_HI: begin
          if (msg_ack) begin
            msg_req <= 1'b0;
            state   <= MU_WAIT_LO;
          end
        end
        MU_WAIT_LO: begin
          if (!msg_ack) begin
            done_q <= 1'b1;
            state  <= MU_IDLE;
          end
        end
        default: state <= MU_IDLE;
      endcase
    end
  end

  // reply word is valid while ack is high
  always_ff @(posedge clk) begin
    if (exec) begin
      result_q <= '0;
    end else if (state == MU_WAIT_HI && msg_ack) begin
      result_q <= msg_reply;
    end
  end

  assign res.result = result_q;
  assign res.done   = done_q;

endmodule

/* hdl/internal_bus.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module internal_bus import core_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start_req,
  output logic                  start_ack,
  input  run_params_t           start,
  output logic                  mem_req,
  input  logic                  mem_ack,
  output mem_op_t               mem_bus,
  input  logic [`DATA_SIZE-1:0] mem_rdata,
  output logic                  msg_req,
  input  logic                  msg_ack,
  output cpu_msg_t              msg_out,
  input  logic [`DATA_SIZE-1:0] msg_reply
);

  logic                  bus_go;
  mem_op_t               bus_op;
  logic                  bus_done;
  logic [`DATA_SIZE-1:0] bus_rdata;
  logic                  exec;
  cmd_word_t             cmd;
  logic [`DATA_SIZE-1:0] src0;
  logic [`DATA_SIZE-1:0] src1;
  unit_result_t          alu_res;
  unit_result_t          msg_res;

  cmd_sequencer cmd_sequencer_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .start_req (start_req),
    .start_ack (start_ack),
    .start     (start),
    .bus_go    (bus_go),
    .bus_op    (bus_op),
    .bus_done  (bus_done),
    .bus_rdata (bus_rdata),
    .exec      (exec),
    .cmd       (cmd),
    .src0      (src0),
    .src1      (src1),
    .alu_res   (alu_res),
    .msg_res   (msg_res)
  );

  bus_master bus_master_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (bus_go),
    .op        (bus_op),
    .done      (bus_done),
    .rdata     (bus_rdata),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_bus   (mem_bus),
    .mem_rdata (mem_rdata)
  );

  // both units see every command and return zero when it is not theirs
  alu_unit alu_unit_i (
    .clk    (clk),
    .arst_n (arst_n),
    .exec   (exec),
    .cmd    (cmd),
    .src0   (src0),
    .src1   (src1),
    .res    (alu_res)
  );

  msg_unit msg_unit_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .exec      (exec),
    .cmd       (cmd),
    .src0      (src0),
    .res       (msg_res),
    .msg_req   (msg_req),
    .msg_ack   (msg_ack),
    .msg_out   (msg_out),
    .msg_reply (msg_reply)
  );

endmodule

/* testbench/tb_internal_bus.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module tb_internal_bus import core_pkg::*; ();

  localparam int RUN_LIMIT = 5000;
  localparam int DROP_LIMIT = 10;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  start_req;
  logic                  start_ack;
  run_params_t           start;
  logic                  mem_req;
  logic                  mem_ack;
  mem_op_t               mem_bus;
  logic [`DATA_SIZE-1:0] mem_rdata;
  logic                  msg_req;
  logic                  msg_ack;
  cpu_msg_t              msg_out;
  logic [`DATA_SIZE-1:0] msg_reply;

  logic [`DATA_SIZE-1:0] mem [0:65535];
  logic [`DATA_SIZE-1:0] shadow [0:255];
  logic [`DATA_SIZE-1:0] ref_words [0:5];

  int                    errors;
  logic [15:0]           lfsr_state;
  logic                  use_delay;
  logic [`ADDR_SIZE-1:0] run_cb;
  logic [`ADDR_SIZE-1:0] run_db;
  logic [`ADDR_SIZE-1:0] max_fetch;

  // responder state
  int                    mem_phase = 0;
  int                    mem_wait;
  mem_op_t               mem_held;
  int                    msg_phase = 0;
  int                    msg_wait;
  cpu_msg_t              last_msg;
  int                    msg_count = 0;

  internal_bus internal_bus_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .start_req (start_req),
    .start_ack (start_ack),
    .start     (start),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_bus   (mem_bus),
    .mem_rdata (mem_rdata),
    .msg_req   (msg_req),
    .msg_ack   (msg_ack),
    .msg_out   (msg_out),
    .msg_reply (msg_reply)
  );

  always #5 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic int take_bits(input int count);
    int   value;
    logic bit_out;
    value = 0;
    for (int i = 0; i < count; i++) begin
      bit_out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) lfsr_state = lfsr_state ^ 16'hB400;
      value = (value << 1) | bit_out;
    end
    return value;
  endfunction

  function automatic logic [31:0] fill_word(input logic [15:0] addr);
    return {addr ^ 16'hA5C3, addr};
  endfunction

  function automatic logic [31:0] alu_cmd(input logic [3:0] code, input logic [7:0] dst,
                                          input logic [7:0] s0, input logic [7:0] s1);
    return {code, dst, s0, s1, 4'h0};
  endfunction

  function automatic logic [31:0] msg_cmd(input logic [7:0] dst, input logic [7:0] s0,
                                          input logic [3:0] target, input logic [7:0] tag);
    return {`CMD_MSG, dst, s0, target, tag};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [63:0] expv,
                             input logic [63:0] actv);
    assert (actv === expv) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, expv, actv);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    $display("errors: %0d", errors);
    $display("TEST FAIL");
    $finish;
  endtask

  // memory side of the four-phase bus
  always @(posedge clk) begin
    #1;
    if (mem_phase == 0 && mem_req) begin
      mem_held  = mem_bus;
      mem_wait  = use_delay ? take_bits(3) : 0;
      mem_phase = 1;
    end else if (mem_phase == 1) begin
      assert (mem_req) else begin
        $display("mem_req dropped before mem_ack was raised");
        errors++;
      end
      assert (mem_bus === mem_held) else begin
        $display("mem_bus changed while mem_req waited for mem_ack");
        errors++;
      end
    end
    if (mem_phase == 1) begin
      if (mem_wait == 0) begin
        if (mem_held.write) begin
          mem[mem_held.addr] = mem_held.wdata;
        end else begin
          mem_rdata = mem[mem_held.addr];
          if (mem_held.addr >= run_cb && mem_held.addr < run_db &&
              mem_held.addr > max_fetch) begin
            max_fetch = mem_held.addr;
          end
        end
        mem_ack   = 1'b1;
        mem_phase = 2;
      end else begin
        mem_wait--;
      end
    end else if (mem_phase == 2 && !mem_req) begin
      mem_ack   = 1'b0;
      mem_phase = 0;
    end
  end

  // message responder replies with payload plus tag
  always @(posedge clk) begin
    #1;
    if (msg_phase == 0 && msg_req) begin
      last_msg  = msg_out;
      msg_wait  = use_delay ? take_bits(3) : 0;
      msg_phase = 1;
    end else if (msg_phase == 1) begin
      assert (msg_req) else begin
        $display("msg_req dropped before msg_ack was raised");
        errors++;
      end
      assert (msg_out === last_msg) else begin
        $display("msg_out changed while msg_req waited for msg_ack");
        errors++;
      end
    end
    if (msg_phase == 1) begin
      if (msg_wait == 0) begin
        msg_reply = last_msg.payload + {24'h0, last_msg.tag};
        msg_ack   = 1'b1;
        msg_count++;
        msg_phase = 2;
      end else begin
        msg_wait--;
      end
    end else if (msg_phase == 2 && !msg_req) begin
      msg_ack   = 1'b0;
      msg_phase = 0;
    end
  end

  // start handshake around one whole program
  task automatic run_program(input logic [15:0] cb, input logic [15:0] db);
    int n;
    run_cb          = cb;
    run_db          = db;
    max_fetch       = '0;
    start.cmd_base  = cb;
    start.data_base = db;
    start_req       = 1'b1;
    n = 0;
    while (!start_ack && n < RUN_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!start_ack) stop_on_timeout("start_ack to rise");
    // ack has to stay up while req is still high
    for (int i = 0; i < 2; i++) begin
      next_cycle();
      assert (start_ack) else begin
        $display("start_ack fell while start_req was still high");
        errors++;
      end
    end
    start_req = 1'b0;
    n = 0;
    while (start_ack && n < DROP_LIMIT) begin
      next_cycle();
      n++;
    end
    if (start_ack) stop_on_timeout("start_ack to fall");
    next_cycle();
  endtask

  // reference execution of a program on a copy of the data words
  task automatic model_program(input logic [15:0] cb, input logic [15:0] db);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    int          ip;
    for (int i = 0; i < 256; i++) shadow[i] = mem[db + i];
    ip = 0;
    w  = mem[cb];
    while (w[31:28] != `CMD_STOP && ip < 256) begin
      a = shadow[w[19:12]];
      b = shadow[w[11:4]];
      case (w[31:28])
        `CMD_ADD: r = a + b;
        `CMD_SUB: r = a - b;
        `CMD_AND: r = a & b;
        `CMD_OR:  r = a | b;
        `CMD_XOR: r = a ^ b;
        `CMD_MSG: r = a + {24'h0, w[7:0]};
        default:  r = '0;
      endcase
      shadow[w[27:20]] = r;
      ip++;
      w = mem[cb + ip];
    end
  endtask

  // five alu codes and one message with results at offsets 10 to 15
  task automatic load_mixed(input logic [15:0] cb, input logic [15:0] db);
    mem[db + 0] = 32'h12345678;
    mem[db + 1] = 32'h0F0F00FF;
    mem[db + 2] = 32'd5;
    mem[db + 3] = 32'd7;
    for (int i = 10; i < 16; i++) mem[db + i] = fill_word(db + i);
    mem[cb + 0] = alu_cmd(`CMD_ADD, 8'd10, 8'd0, 8'd1);
    mem[cb + 1] = alu_cmd(`CMD_SUB, 8'd11, 8'd2, 8'd3);
    mem[cb + 2] = alu_cmd(`CMD_AND, 8'd12, 8'd0, 8'd1);
    mem[cb + 3] = alu_cmd(`CMD_OR, 8'd13, 8'd0, 8'd1);
    mem[cb + 4] = alu_cmd(`CMD_XOR, 8'd14, 8'd0, 8'd1);
    mem[cb + 5] = msg_cmd(8'd15, 8'd0, 4'h3, 8'h5A);
    mem[cb + 6] = alu_cmd(`CMD_STOP, 8'd0, 8'd0, 8'd0);
    // expected words at offsets 10 to 15
    ref_words[0] = 32'h12345678 + 32'h0F0F00FF;
    // 5 - 7 wraps
    ref_words[1] = 32'hFFFFFFFE;
    ref_words[2] = 32'h12345678 & 32'h0F0F00FF;
    ref_words[3] = 32'h12345678 | 32'h0F0F00FF;
    ref_words[4] = 32'h12345678 ^ 32'h0F0F00FF;
    ref_words[5] = 32'h12345678 + 32'h5A;
  endtask

  task automatic reset_idle();
    for (int i = 0; i < 11; i++) begin
      if (i == 7) arst_n = 1'b1;
      check_value("reset_idle start_ack", 0, start_ack);
      check_value("reset_idle mem_req", 0, mem_req);
      check_value("reset_idle msg_req", 0, msg_req);
      check_value("reset_idle mem_bus", 0, mem_bus);
      check_value("reset_idle msg_out", 0, msg_out);
      next_cycle();
    end
  endtask

  task automatic alu_ops();
    load_mixed(16'h1000, 16'h2000);
    run_program(16'h1000, 16'h2000);
    check_value("alu_ops add", ref_words[0], mem[16'h2000 + 10]);
    check_value("alu_ops sub", ref_words[1], mem[16'h2000 + 11]);
    check_value("alu_ops and", ref_words[2], mem[16'h2000 + 12]);
    check_value("alu_ops or", ref_words[3], mem[16'h2000 + 13]);
    check_value("alu_ops xor", ref_words[4], mem[16'h2000 + 14]);
    check_value("alu_ops msg merge", ref_words[5], mem[16'h2000 + 15]);
  endtask

  task automatic message_send();
    int count_before;
    count_before = msg_count;
    mem[16'h2040 + 2]  = 32'hCAFE0001;
    mem[16'h2040 + 20] = fill_word(16'h2040 + 20);
    mem[16'h1040 + 0]  = msg_cmd(8'd20, 8'd2, 4'h9, 8'hC3);
    mem[16'h1040 + 1]  = alu_cmd(`CMD_STOP, 8'd0, 8'd0, 8'd0);
    run_program(16'h1040, 16'h2040);
    check_value("message_send count", count_before + 1, msg_count);
    check_value("message_send msg_out", {4'h9, 8'hC3, 32'hCAFE0001}, last_msg);
    check_value("message_send dst", 32'hCAFE0001 + 32'hC3, mem[16'h2040 + 20]);
  endtask

  task automatic program_order();
    mem[16'h2100 + 0] = 32'd3;
    mem[16'h2100 + 1] = 32'd10;
    mem[16'h1100 + 0] = alu_cmd(`CMD_ADD, 8'd2, 8'd0, 8'd1);
    mem[16'h1100 + 1] = alu_cmd(`CMD_SUB, 8'd3, 8'd2, 8'd0);
    mem[16'h1100 + 2] = alu_cmd(`CMD_XOR, 8'd4, 8'd3, 8'd2);
    mem[16'h1100 + 3] = msg_cmd(8'd5, 8'd4, 4'h1, 8'h07);
    mem[16'h1100 + 4] = alu_cmd(`CMD_AND, 8'd6, 8'd5, 8'd2);
    mem[16'h1100 + 5] = alu_cmd(`CMD_OR, 8'd7, 8'd6, 8'd1);
    mem[16'h1100 + 6] = alu_cmd(`CMD_STOP, 8'd0, 8'd0, 8'd0);
    // never fetched
    mem[16'h1100 + 7] = alu_cmd(`CMD_ADD, 8'd8, 8'd0, 8'd1);
    mem[16'h1100 + 8] = alu_cmd(`CMD_XOR, 8'd9, 8'd0, 8'd1);
    model_program(16'h1100, 16'h2100);
    run_program(16'h1100, 16'h2100);
    for (int i = 0; i < 32; i++) begin
      check_value("program_order data", shadow[i], mem[16'h2100 + i]);
    end
    check_value("program_order last fetch", 16'h1100 + 6, max_fetch);
  endtask

  task automatic random_backpressure();
    use_delay = 1'b1;
    load_mixed(16'h1000, 16'h2000);
    run_program(16'h1000, 16'h2000);
    for (int i = 0; i < 6; i++) begin
      check_value("random_backpressure", ref_words[i], mem[16'h2000 + 10 + i]);
    end
    use_delay = 1'b0;
  endtask

  task automatic restart_new_base();
    logic [31:0] old_words [0:5];
    for (int i = 0; i < 6; i++) old_words[i] = mem[16'h2000 + 10 + i];
    load_mixed(16'h3000, 16'h4000);
    run_program(16'h3000, 16'h4000);
    for (int i = 0; i < 6; i++) begin
      check_value("restart_new_base new", ref_words[i], mem[16'h4000 + 10 + i]);
      check_value("restart_new_base old", old_words[i], mem[16'h2000 + 10 + i]);
    end
    check_value("restart_new_base last fetch", 16'h3000 + 6, max_fetch);
  endtask

  initial begin
    errors     = 0;
    lfsr_state = 16'd26981;
    use_delay  = 1'b0;
    run_cb     = '0;
    run_db     = '0;
    max_fetch  = '0;
    arst_n     = 1'b0;
    start_req  = 1'b0;
    start      = '0;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    msg_ack    = 1'b0;
    msg_reply  = '0;
    for (int a = 0; a < 65536; a++) mem[a] = fill_word(16'(a));
    next_cycle();
    reset_idle();
    alu_ops();
    message_send();
    program_order();
    random_backpressure();
    restart_new_base();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+include
hdl/core_pkg.sv
hdl/bus_master.sv
hdl/cmd_sequencer.sv
hdl/alu_unit.sv
hdl/msg_unit.sv
hdl/internal_bus.sv
testbench/tb_internal_bus.sv

/* Bender.yml */
package:
  name: internal_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/core_pkg.sv
      - hdl/bus_master.sv
      - hdl/cmd_sequencer.sv
      - hdl/alu_unit.sv
      - hdl/msg_unit.sv
      - hdl/internal_bus.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_internal_bus.sv
